// File: Makefile
VERILATOR ?= verilator
TOP       := tb_branch_exec
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the pass message shows up as a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: design/branch_cfg.svh
// Branch cluster sizes
`ifndef BRANCH_CFG_SVH_
`define BRANCH_CFG_SVH_

// Datapath width
`define XLEN 32

// ROB tag width
`define ROB_IDX_LEN 4

// Branch immediate width, signed byte offset with bit 0 always zero
`define B_IMM_LEN 13

// Reservation station entries
`define BRS_DEPTH 8

`endif

// File: design/branch_exec_top.sv
// Branch execution cluster
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_exec_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     arbiter_valid_i,
    output logic                     arbiter_ready_o,
    input  isa_pkg::branch_type_t    branch_type_i,
    input  logic                     rs1_ready_i,
    input  expipe_pkg::rob_idx_t     rs1_idx_i,
    input  isa_pkg::xlen_t           rs1_value_i,
    input  logic                     rs2_ready_i,
    input  expipe_pkg::rob_idx_t     rs2_idx_i,
    input  isa_pkg::xlen_t           rs2_value_i,
    input  isa_pkg::b_imm_t          imm_i,
    input  expipe_pkg::rob_idx_t     dest_idx_i,
    input  isa_pkg::xlen_t           pred_pc_i,
    input  isa_pkg::xlen_t           pred_target_i,
    input  logic                     pred_taken_i,
    input  logic                     cdb_valid_i,          // Snoop side
    input  expipe_pkg::rob_idx_t     cdb_rob_idx_i,
    input  isa_pkg::xlen_t           cdb_value_i,
    input  logic                     cdb_except_raised_i,
    input  logic                     cdb_ready_i,          // Write-back side
    output logic                     cdb_valid_o,
    output expipe_pkg::rob_idx_t     cdb_rob_idx_o,
    output isa_pkg::xlen_t           cdb_value_o,
    output logic                     cdb_except_raised_o,
    output expipe_pkg::except_code_t cdb_except_code_o
);
    expipe_pkg::cdb_data_t cdb_snoop;
    expipe_pkg::cdb_data_t cdb_out;

    // Snooped word, code field not carried on the snoop port
    assign cdb_snoop.rob_idx       = cdb_rob_idx_i;
    assign cdb_snoop.value         = cdb_value_i;
    assign cdb_snoop.except_raised = cdb_except_raised_i;
    assign cdb_snoop.except_code   = expipe_pkg::EXC_NONE;

    bu_issue_if u_bu_if (.clk_i(clk_i));

    branch_rs #(.RS_DEPTH(`BRS_DEPTH)) u_rs (
        .clk_i, .rst_n_i, .flush_i,
        .arbiter_valid_i, .arbiter_ready_o,
        .branch_type_i,
        .rs1_ready_i, .rs1_idx_i, .rs1_value_i,
        .rs2_ready_i, .rs2_idx_i, .rs2_value_i,
        .imm_i, .dest_idx_i,
        .pred_pc_i, .pred_target_i, .pred_taken_i,
        .cdb_valid_i, .cdb_data_i(cdb_snoop),
        .cdb_ready_i, .cdb_valid_o, .cdb_data_o(cdb_out),
        .bu(u_bu_if)
    );

    branch_unit u_bu (
        .clk_i, .rst_n_i, .flush_i,
        .bu(u_bu_if)
    );

    assign cdb_rob_idx_o       = cdb_out.rob_idx;
    assign cdb_value_o         = cdb_out.value;
    assign cdb_except_raised_o = cdb_out.except_raised;
    assign cdb_except_code_o   = cdb_out.except_code;

endmodule

`default_nettype wire

// File: design/branch_rs.sv
// Branch reservation station
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_rs #(
    parameter int unsigned RS_DEPTH = `BRS_DEPTH  // Power of two, 2 to 16
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   arbiter_valid_i,
    output logic                   arbiter_ready_o,
    input  isa_pkg::branch_type_t  branch_type_i,
    input  logic                   rs1_ready_i,
    input  expipe_pkg::rob_idx_t   rs1_idx_i,
    input  isa_pkg::xlen_t         rs1_value_i,
    input  logic                   rs2_ready_i,
    input  expipe_pkg::rob_idx_t   rs2_idx_i,
    input  isa_pkg::xlen_t         rs2_value_i,
    input  isa_pkg::b_imm_t        imm_i,
    input  expipe_pkg::rob_idx_t   dest_idx_i,
    input  isa_pkg::xlen_t         pred_pc_i,
    input  isa_pkg::xlen_t         pred_target_i,
    input  logic                   pred_taken_i,
    input  logic                   cdb_valid_i,   // Snooped broadcast
    input  expipe_pkg::cdb_data_t  cdb_data_i,
    input  logic                   cdb_ready_i,
    output logic                   cdb_valid_o,
    output expipe_pkg::cdb_data_t  cdb_data_o,
    bu_issue_if.rs                 bu
);
    localparam int unsigned IDX_W = $clog2(RS_DEPTH);

    typedef struct packed {
        isa_pkg::branch_type_t    branch_type;
        expipe_pkg::rob_idx_t     rs1_idx;     // Producer of operand 1
        isa_pkg::xlen_t           rs1_value;
        expipe_pkg::rob_idx_t     rs2_idx;     // Producer of operand 2
        isa_pkg::xlen_t           rs2_value;
        isa_pkg::b_imm_t          imm;
        isa_pkg::xlen_t           pc;
        isa_pkg::xlen_t           pred_target;
        logic                     pred_taken;
        expipe_pkg::rob_idx_t     res_idx;     // Own ROB tag
        logic                     mispredicted;
        logic                     except_raised;
        expipe_pkg::except_code_t except_code;
    } entry_t;

    entry_t              data_q [RS_DEPTH];
    logic [RS_DEPTH-1:0] valid_q;    // Slot holds an instruction
    logic [RS_DEPTH-1:0] busy_q;     // In flight in the unit
    logic [RS_DEPTH-1:0] rs1_rdy_q;
    logic [RS_DEPTH-1:0] rs2_rdy_q;
    logic [RS_DEPTH-1:0] res_rdy_q;  // Outcome captured

    logic [IDX_W-1:0]    tail_idx;
    logic [IDX_W-1:0]    ex_idx;
    logic [IDX_W-1:0]    wr_idx;
    logic [IDX_W-1:0]    head_idx;

    logic                snoop_ok;   // Clean broadcast on the bus
    logic [RS_DEPTH-1:0] hit1;
    logic [RS_DEPTH-1:0] hit2;
    logic                push_hit1;  // Broadcast meets the incoming entry
    logic                push_hit2;
    logic                push;
    logic                issue;
    logic                pop;

    // Tag match against every waiting operand
    always_comb begin
        snoop_ok  = cdb_valid_i && !cdb_data_i.except_raised;
        push_hit1 = snoop_ok && !rs1_ready_i && (rs1_idx_i == cdb_data_i.rob_idx);
        push_hit2 = snoop_ok && !rs2_ready_i && (rs2_idx_i == cdb_data_i.rob_idx);
        for (int i = 0; i < RS_DEPTH; i++) begin
            hit1[i] = snoop_ok && valid_q[i] && !rs1_rdy_q[i]
                      && (data_q[i].rs1_idx == cdb_data_i.rob_idx);
            hit2[i] = snoop_ok && valid_q[i] && !rs2_rdy_q[i]
                      && (data_q[i].rs2_idx == cdb_data_i.rob_idx);
        end
    end

    assign arbiter_ready_o = !valid_q[tail_idx];          // Tail slot free
    assign push            = arbiter_valid_i && arbiter_ready_o;
    assign bu.issue_valid  = valid_q[ex_idx] && !busy_q[ex_idx] && !res_rdy_q[ex_idx]
                             && rs1_rdy_q[ex_idx] && rs2_rdy_q[ex_idx];
    assign issue           = bu.issue_valid && bu.issue_ready;
    assign cdb_valid_o     = valid_q[head_idx] && res_rdy_q[head_idx];
    assign pop             = cdb_valid_o && cdb_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= '0;
            busy_q    <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            res_rdy_q <= '0;
        end else if (flush_i) begin
            valid_q   <= '0;
            busy_q    <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            res_rdy_q <= '0;
        end else begin
            rs1_rdy_q <= rs1_rdy_q | hit1;  // Wake-up from the bus
            rs2_rdy_q <= rs2_rdy_q | hit2;
            if (push) begin
                valid_q[tail_idx]   <= 1'b1;
                busy_q[tail_idx]    <= 1'b0;
                res_rdy_q[tail_idx] <= 1'b0;
                rs1_rdy_q[tail_idx] <= rs1_ready_i | push_hit1;
                rs2_rdy_q[tail_idx] <= rs2_ready_i | push_hit2;
            end
            if (issue) begin
                busy_q[ex_idx] <= 1'b1;
            end
            if (bu.res_valid) begin
                busy_q[wr_idx]    <= 1'b0;
                res_rdy_q[wr_idx] <= 1'b1;
            end
            if (pop) begin
                valid_q[head_idx] <= 1'b0;  // Slot reusable
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (hit1[i]) data_q[i].rs1_value <= cdb_data_i.value;
            if (hit2[i]) data_q[i].rs2_value <= cdb_data_i.value;
        end
        if (push) begin
            data_q[tail_idx].branch_type <= branch_type_i;
            data_q[tail_idx].rs1_idx     <= rs1_idx_i;
            data_q[tail_idx].rs1_value   <= push_hit1 ? cdb_data_i.value : rs1_value_i;
            data_q[tail_idx].rs2_idx     <= rs2_idx_i;
            data_q[tail_idx].rs2_value   <= push_hit2 ? cdb_data_i.value : rs2_value_i;
            data_q[tail_idx].imm         <= imm_i;
            data_q[tail_idx].pc          <= pred_pc_i;
            data_q[tail_idx].pred_target <= pred_target_i;
            data_q[tail_idx].pred_taken  <= pred_taken_i;
            data_q[tail_idx].res_idx     <= dest_idx_i;
        end
        if (bu.res_valid) begin
            data_q[wr_idx].mispredicted  <= bu.mispredict;
            data_q[wr_idx].except_raised <= bu.except_raised;
            data_q[wr_idx].except_code   <= bu.except_code;
        end
    end

    // Pointers, all cleared by a flush
    modn_counter #(.N(RS_DEPTH)) u_tail_cnt (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(push), .clr_i(flush_i), .count_o(tail_idx)
    );
    modn_counter #(.N(RS_DEPTH)) u_ex_cnt (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(issue), .clr_i(flush_i), .count_o(ex_idx)
    );
    modn_counter #(.N(RS_DEPTH)) u_wr_cnt (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(bu.res_valid), .clr_i(flush_i),
        .count_o(wr_idx)
    );
    modn_counter #(.N(RS_DEPTH)) u_head_cnt (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(pop), .clr_i(flush_i), .count_o(head_idx)
    );

    // Operands forwarded from the issue slot
    assign bu.branch_type = data_q[ex_idx].branch_type;
    assign bu.rs1         = data_q[ex_idx].rs1_value;
    assign bu.rs2         = data_q[ex_idx].rs2_value;
    assign bu.imm         = data_q[ex_idx].imm;
    assign bu.pc          = data_q[ex_idx].pc;
    assign bu.pred_target = data_q[ex_idx].pred_target;
    assign bu.pred_taken  = data_q[ex_idx].pred_taken;

    // Head word, mispredict flag in the value LSB
    assign cdb_data_o.rob_idx       = data_q[head_idx].res_idx;
    assign cdb_data_o.value         = isa_pkg::xlen_t'(data_q[head_idx].mispredicted);
    assign cdb_data_o.except_raised = data_q[head_idx].except_raised;
    assign cdb_data_o.except_code   = data_q[head_idx].except_code;

    a_res_after_operands: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (res_rdy_q & ~(rs1_rdy_q & rs2_rdy_q)) == '0)
        else $error("Entry holds a result without both operands");

    a_res_to_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bu.res_valid |-> busy_q[wr_idx])
        else $error("Result strobe for an entry that is not in flight");

endmodule

`default_nettype wire

// File: design/branch_unit.sv
// Single-stage branch resolver
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_unit (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   flush_i,
    bu_issue_if.bu bu
);
    logic           fire;        // Issue transfer this cycle
    logic           taken;
    isa_pkg::xlen_t target;
    logic           misaligned;  // Taken target off a word boundary
    logic           res_valid_q;
    logic           mispredict_q;
    logic           except_q;

    assign bu.issue_ready = 1'b1;  // Fully pipelined
    assign fire           = bu.issue_valid && bu.issue_ready;

    always_comb begin
        case (bu.branch_type)
            isa_pkg::BEQ:  taken = (bu.rs1 == bu.rs2);
            isa_pkg::BNE:  taken = (bu.rs1 != bu.rs2);
            isa_pkg::BLT:  taken = ($signed(bu.rs1) < $signed(bu.rs2));
            isa_pkg::BGE:  taken = ($signed(bu.rs1) >= $signed(bu.rs2));
            isa_pkg::BLTU: taken = (bu.rs1 < bu.rs2);
            isa_pkg::BGEU: taken = (bu.rs1 >= bu.rs2);
            default:       taken = 1'b0;
        endcase
    end

    // PC plus sign-extended offset
    assign target     = bu.pc + {{(`XLEN-`B_IMM_LEN){bu.imm[`B_IMM_LEN-1]}}, bu.imm};
    assign misaligned = taken && (target[1:0] != 2'b00);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;  // Drop the in-flight result
        end else begin
            res_valid_q <= fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            // Wrong direction, or right direction with a wrong target
            mispredict_q <= (taken != bu.pred_taken) || (taken && (target != bu.pred_target));
            except_q     <= misaligned;
        end
    end

    assign bu.res_valid     = res_valid_q;
    assign bu.mispredict    = mispredict_q;
    assign bu.except_raised = except_q;
    assign bu.except_code   = except_q ? expipe_pkg::EXC_INSTR_MISALIGNED : expipe_pkg::EXC_NONE;

    a_res_follows_issue: assert property (@(posedge bu.clk_i) disable iff (!rst_n_i)
        bu.res_valid |-> $past(bu.issue_valid && bu.issue_ready))
        else $error("Result strobe without an issue one cycle earlier");

endmodule

`default_nettype wire

// File: design/bu_issue_if.sv
// Station to branch unit link
`timescale 1ns/1ps
`default_nettype none

interface bu_issue_if (
    input logic clk_i
);
    // Issue group
    logic                     issue_valid;
    logic                     issue_ready;  // Back-pressure from the unit
    isa_pkg::branch_type_t    branch_type;
    isa_pkg::xlen_t           rs1;
    isa_pkg::xlen_t           rs2;
    isa_pkg::b_imm_t          imm;
    isa_pkg::xlen_t           pc;
    isa_pkg::xlen_t           pred_target;
    logic                     pred_taken;

    // Result group, one strobe per issued branch
    logic                     res_valid;
    logic                     mispredict;
    logic                     except_raised;
    expipe_pkg::except_code_t except_code;

    modport rs (
        input  clk_i, issue_ready, res_valid, mispredict, except_raised, except_code,
        output issue_valid, branch_type, rs1, rs2, imm, pc, pred_target, pred_taken
    );

    modport bu (
        input  clk_i, issue_valid, branch_type, rs1, rs2, imm, pc, pred_target, pred_taken,
        output issue_ready, res_valid, mispredict, except_raised, except_code
    );

endinterface

`default_nettype wire

// File: design/expipe_pkg.sv
// Execution pipeline types
`default_nettype none

`include "branch_cfg.svh"

package expipe_pkg;

    typedef logic [`ROB_IDX_LEN-1:0] rob_idx_t;  // ROB entry tag

    // Only meaningful while the raised flag is set
    typedef enum logic [3:0] {
        EXC_NONE             = 4'h0,
        EXC_INSTR_MISALIGNED = 4'h1
    } except_code_t;

    // One broadcast on the common data bus
    typedef struct packed {
        rob_idx_t        rob_idx;        // Producer tag
        isa_pkg::xlen_t  value;          // Result value
        logic            except_raised;  // Producer faulted
        except_code_t    except_code;
    } cdb_data_t;

endpackage

`default_nettype wire

// File: design/isa_pkg.sv
// ISA operand and branch types
`default_nettype none

`include "branch_cfg.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]      xlen_t;   // Operand, PC or target
    typedef logic [`B_IMM_LEN-1:0] b_imm_t;  // Signed offset, LSB always zero

    // Encoded as the funct3 field of the branch opcode
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_type_t;

endpackage

`default_nettype wire

// File: design/modn_counter.sv
// Modulo-N pointer counter
`timescale 1ns/1ps
`default_nettype none

module modn_counter #(
    parameter int unsigned N = 8  // Wrap modulus, at least 2
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,     // Advance by one
    input  logic                 clr_i,    // Back to zero, wins over en_i
    output logic [$clog2(N)-1:0] count_o
);
    localparam int unsigned W = $clog2(N);

    logic last;  // Next advance wraps

    assign last = (count_o == W'(N - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0;
        end else if (en_i) begin
            count_o <= last ? '0 : count_o + W'(1);
        end
    end

endmodule

`default_nettype wire

// File: test/tb_branch_exec.sv
// Branch cluster testbench
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module tb_branch_exec;

    localparam int TIMEOUT = 200;  // Cycles per wait loop

    typedef struct packed {
        isa_pkg::branch_type_t bt;
        logic                  r1_rdy;
        logic                  r2_rdy;
        expipe_pkg::rob_idx_t  r1_idx;   // Producer tags while not ready
        expipe_pkg::rob_idx_t  r2_idx;
        expipe_pkg::rob_idx_t  dest;
        isa_pkg::xlen_t        r1_val;   // Final operand values
        isa_pkg::xlen_t        r2_val;
        isa_pkg::b_imm_t       imm;
        isa_pkg::xlen_t        pc;
        isa_pkg::xlen_t        ptgt;
        logic                  ptkn;
    } instr_t;

    typedef struct packed {
        expipe_pkg::rob_idx_t rob;
        logic                 misp;
        logic                 exc;
    } exp_t;

    logic clk;
    logic rst_n;
    logic flush;
    logic arb_valid;
    logic arb_ready;
    isa_pkg::branch_type_t br_type;
    logic rs1_ready;
    logic rs2_ready;
    expipe_pkg::rob_idx_t rs1_idx;
    expipe_pkg::rob_idx_t rs2_idx;
    expipe_pkg::rob_idx_t dest_idx;
    isa_pkg::xlen_t rs1_value;
    isa_pkg::xlen_t rs2_value;
    isa_pkg::b_imm_t imm;
    isa_pkg::xlen_t pred_pc;
    isa_pkg::xlen_t pred_target;
    logic pred_taken;
    logic snoop_valid;                   // Broadcasts from other units
    expipe_pkg::rob_idx_t snoop_rob_idx;
    isa_pkg::xlen_t snoop_value;
    logic snoop_exc;
    logic cdb_ready;
    logic cdb_valid;
    expipe_pkg::rob_idx_t cdb_rob_idx;
    isa_pkg::xlen_t cdb_value;
    logic cdb_exc;
    expipe_pkg::except_code_t cdb_exc_code;

    exp_t        exp_q[$];    // Results still owed in push order
    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'h7f48;

    isa_pkg::branch_type_t all_types [6] = '{isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT,
                                             isa_pkg::BGE, isa_pkg::BLTU, isa_pkg::BGEU};

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    branch_exec_top u_dut (
        .clk_i(clk), .rst_n_i(rst_n), .flush_i(flush),
        .arbiter_valid_i(arb_valid), .arbiter_ready_o(arb_ready),
        .branch_type_i(br_type),
        .rs1_ready_i(rs1_ready), .rs1_idx_i(rs1_idx), .rs1_value_i(rs1_value),
        .rs2_ready_i(rs2_ready), .rs2_idx_i(rs2_idx), .rs2_value_i(rs2_value),
        .imm_i(imm), .dest_idx_i(dest_idx),
        .pred_pc_i(pred_pc), .pred_target_i(pred_target), .pred_taken_i(pred_taken),
        .cdb_valid_i(snoop_valid), .cdb_rob_idx_i(snoop_rob_idx),
        .cdb_value_i(snoop_value), .cdb_except_raised_i(snoop_exc),
        .cdb_ready_i(cdb_ready), .cdb_valid_o(cdb_valid), .cdb_rob_idx_o(cdb_rob_idx),
        .cdb_value_o(cdb_value), .cdb_except_raised_o(cdb_exc),
        .cdb_except_code_o(cdb_exc_code)
    );

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Biasing the sign bit turns signed order into unsigned order
    function automatic logic taken_of(input isa_pkg::branch_type_t bt,
                                      input isa_pkg::xlen_t a, input isa_pkg::xlen_t b);
        isa_pkg::xlen_t sa;
        isa_pkg::xlen_t sb;
        sa = a ^ 32'h8000_0000;
        sb = b ^ 32'h8000_0000;
        case (bt)
            isa_pkg::BEQ:  return a == b;
            isa_pkg::BNE:  return a != b;
            isa_pkg::BLT:  return sa < sb;
            isa_pkg::BGE:  return !(sa < sb);
            isa_pkg::BLTU: return a < b;
            isa_pkg::BGEU: return !(a < b);
            default:       return 1'b0;
        endcase
    endfunction

    function automatic isa_pkg::xlen_t target_of(input isa_pkg::xlen_t pc_v,
                                                 input isa_pkg::b_imm_t imm_v);
        return pc_v + 32'($signed(imm_v));  // Sign-extended byte offset
    endfunction

    // Expected CDB word for one branch
    function automatic exp_t model_result(input instr_t in);
        exp_t           e;
        logic           taken;
        isa_pkg::xlen_t tgt;
        taken  = taken_of(in.bt, in.r1_val, in.r2_val);
        tgt    = target_of(in.pc, in.imm);
        e.rob  = in.dest;
        e.misp = taken ? (!in.ptkn || (tgt != in.ptgt)) : in.ptkn;  // Direction or target
        e.exc  = taken && (tgt[1:0] != 2'b00);
        return e;
    endfunction

    // Random ready branch with an aligned target and a coin-flip prediction
    function automatic instr_t rand_instr(input isa_pkg::branch_type_t bt,
                                          input expipe_pkg::rob_idx_t dest);
        instr_t      in;
        logic [31:0] r;
        logic [31:0] v;
        r         = next_rand();
        in        = '0;
        in.bt     = bt;
        in.dest   = dest;
        in.r1_rdy = 1'b1;
        in.r2_rdy = 1'b1;
        in.r1_val = next_rand();
        v         = next_rand();
        in.r2_val = r[0] ? in.r1_val : v;  // Equal operands now and then
        in.imm    = {r[14:4], 2'b00};
        v         = next_rand();
        in.pc     = {v[31:2], 2'b00};
        in.ptkn   = r[1];
        in.ptgt   = target_of(in.pc, in.imm) + (r[2] ? 32'd0 : 32'd4);
        return in;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;  // Drive and look just after the edge
    endtask

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // Every pop is checked against the head of the expected queue
    task automatic monitor_cdb();
        exp_t e;
        forever begin
            @(posedge clk);
            if (rst_n && cdb_valid && cdb_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("CDB output while no result was outstanding");
                end else begin
                    e = exp_q.pop_front();
                    compare("cdb_rob_idx_o", 32'(cdb_rob_idx), 32'(e.rob));
                    compare("cdb_value_o", cdb_value, 32'(e.misp));
                    compare("cdb_except_raised_o", 32'(cdb_exc), 32'(e.exc));
                    if (e.exc) begin
                        compare("cdb_except_code_o", 32'(cdb_exc_code),
                                32'(expipe_pkg::EXC_INSTR_MISALIGNED));
                    end
                end
            end
        end
    endtask

    // Value of a not-ready operand is junk on the port
    task automatic push_instr(input instr_t in);
        int n;
        br_type     = in.bt;
        rs1_ready   = in.r1_rdy;
        rs1_idx     = in.r1_idx;
        rs1_value   = in.r1_rdy ? in.r1_val : ~in.r1_val;
        rs2_ready   = in.r2_rdy;
        rs2_idx     = in.r2_idx;
        rs2_value   = in.r2_rdy ? in.r2_val : ~in.r2_val;
        imm         = in.imm;
        dest_idx    = in.dest;
        pred_pc     = in.pc;
        pred_target = in.ptgt;
        pred_taken  = in.ptkn;
        arb_valid   = 1'b1;
        n = 0;
        while (!arb_ready && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!arb_ready) begin
            report_failure("Timeout waiting for arbiter_ready_o");
        end else begin
            step();  // Accepted on this edge
        end
        arb_valid = 1'b0;
    endtask

    task automatic set_snoop(input expipe_pkg::rob_idx_t tag, input isa_pkg::xlen_t val,
                             input logic exc);
        snoop_valid   = 1'b1;
        snoop_rob_idx = tag;
        snoop_value   = val;
        snoop_exc     = exc;
    endtask

    task automatic snoop(input expipe_pkg::rob_idx_t tag, input isa_pkg::xlen_t val,
                         input logic exc);
        set_snoop(tag, val, exc);
        step();
        snoop_valid = 1'b0;
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            step();
            n++;
        end
        if (exp_q.size() != 0) begin
            report_failure($sformatf("Timeout, %0d %s results never reached the CDB",
                                     exp_q.size(), what));
            exp_q.delete();
        end
    endtask

    task automatic reset_state_check();
        compare("arbiter_ready_o after reset", 32'(arb_ready), 32'd1);
        compare("cdb_valid_o after reset", 32'(cdb_valid), 32'd0);
    endtask

    task automatic resolve_each_type();
        instr_t in;
        cdb_ready = 1'b1;
        for (int round = 0; round < 4; round++) begin
            for (int t = 0; t < 6; t++) begin
                in = rand_instr(all_types[t], expipe_pkg::rob_idx_t'(round * 6 + t));
                exp_q.push_back(model_result(in));
                push_instr(in);
            end
        end
        wait_drained("branch type");
    endtask

    task automatic operand_wakeup();
        instr_t in;
        cdb_ready = 1'b1;
        // Taken and predicted taken so a stale operand flips the outcome
        in        = rand_instr(isa_pkg::BEQ, 4'd3);
        in.r2_val = in.r1_val;
        in.ptkn   = 1'b1;
        in.ptgt   = target_of(in.pc, in.imm);
        in.r1_rdy = 1'b0;
        in.r1_idx = 4'd9;
        in.r2_rdy = 1'b0;
        in.r2_idx = 4'd10;
        exp_q.push_back(model_result(in));
        push_instr(in);
        snoop(4'd9, ~in.r1_val, 1'b1);  // Faulted producer
        snoop(4'd10, in.r2_val, 1'b0);
        for (int i = 0; i < 8; i++) begin
            step();
            checks++;
            if (cdb_valid) begin
                report_failure("Branch completed on a faulted broadcast");
            end
        end
        snoop(4'd9, in.r1_val, 1'b0);
        wait_drained("woken");
        // Broadcast in the same cycle as the push, equal operands predicted not taken
        in        = rand_instr(isa_pkg::BNE, 4'd4);
        in.r2_val = in.r1_val;
        in.ptkn   = 1'b0;
        in.r1_rdy = 1'b0;
        in.r1_idx = 4'd12;
        exp_q.push_back(model_result(in));
        set_snoop(4'd12, in.r1_val, 1'b0);
        push_instr(in);
        snoop_valid = 1'b0;
        wait_drained("push-time wake-up");
    endtask

    task automatic misaligned_targets();
        instr_t in;
        cdb_ready = 1'b1;
        in        = rand_instr(isa_pkg::BEQ, 4'd5);
        in.r2_val = in.r1_val;
        in.imm    = 13'h0006;  // Halfword offset
        in.ptkn   = 1'b1;
        in.ptgt   = target_of(in.pc, in.imm);
        exp_q.push_back(model_result(in));
        push_instr(in);
        in.dest   = 4'd6;
        in.r2_val = ~in.r1_val;  // Same branch with unequal operands
        exp_q.push_back(model_result(in));
        push_instr(in);
        in.bt     = isa_pkg::BNE;
        in.dest   = 4'd7;
        in.imm    = 13'h1FFA;  // Backward offset still off a word
        exp_q.push_back(model_result(in));
        push_instr(in);
        wait_drained("misaligned");
    endtask

    task automatic stall_and_drain();
        instr_t         in;
        logic [31:0]    head_rob;
        isa_pkg::xlen_t head_val;
        logic [31:0]    head_exc;
        logic [31:0]    head_code;
        int             n;
        cdb_ready = 1'b0;
        for (int i = 0; i < `BRS_DEPTH; i++) begin
            in = rand_instr(all_types[i % 6], expipe_pkg::rob_idx_t'(i + 8));
            exp_q.push_back(model_result(in));
            push_instr(in);
        end
        compare("arbiter_ready_o with station full", 32'(arb_ready), 32'd0);
        n = 0;
        while (!cdb_valid && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!cdb_valid) begin
            report_failure("Timeout waiting for cdb_valid_o under back-pressure");
        end
        head_rob  = 32'(cdb_rob_idx);
        head_val  = cdb_value;
        head_exc  = 32'(cdb_exc);
        head_code = 32'(cdb_exc_code);
        repeat (6) begin
            step();
            compare("cdb_valid_o while stalled", 32'(cdb_valid), 32'd1);
            compare("cdb_rob_idx_o while stalled", 32'(cdb_rob_idx), head_rob);
            compare("cdb_value_o while stalled", cdb_value, head_val);
            compare("cdb_except_raised_o while stalled", 32'(cdb_exc), head_exc);
            compare("cdb_except_code_o while stalled", 32'(cdb_exc_code), head_code);
            compare("arbiter_ready_o while stalled", 32'(arb_ready), 32'd0);
        end
        cdb_ready = 1'b1;
        wait_drained("back-pressure");
    endtask

    task automatic flush_pending();
        instr_t in;
        cdb_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            in = rand_instr(all_types[i], expipe_pkg::rob_idx_t'(i));
            if (i >= 2) begin
                in.r1_rdy = 1'b0;  // Producer never broadcasts
                in.r1_idx = 4'd14;
            end
            push_instr(in);
        end
        repeat (2) step();
        compare("cdb_valid_o before flush", 32'(cdb_valid), 32'd1);
        flush = 1'b1;
        step();
        flush     = 1'b0;
        cdb_ready = 1'b1;
        for (int i = 0; i < 20; i++) begin
            step();
            checks++;
            if (cdb_valid) begin
                report_failure("Flushed branch reached the CDB");
            end
        end
        compare("arbiter_ready_o after flush", 32'(arb_ready), 32'd1);
        in = rand_instr(isa_pkg::BLT, 4'd15);
        exp_q.push_back(model_result(in));
        push_instr(in);
        wait_drained("post-flush");
    endtask

    initial begin
        int n;
        flush         = 1'b0;
        arb_valid     = 1'b0;
        br_type       = isa_pkg::BEQ;
        rs1_ready     = 1'b0;
        rs2_ready     = 1'b0;
        rs1_idx       = '0;
        rs2_idx       = '0;
        dest_idx      = '0;
        rs1_value     = '0;
        rs2_value     = '0;
        imm           = '0;
        pred_pc       = '0;
        pred_target   = '0;
        pred_taken    = 1'b0;
        snoop_valid   = 1'b0;
        snoop_rob_idx = '0;
        snoop_value   = '0;
        snoop_exc     = 1'b0;
        cdb_ready     = 1'b0;
        fork
            monitor_cdb();
        join_none
        n = 0;
        while (!rst_n && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!rst_n) begin
            report_failure("Reset never released");
        end
        step();
        reset_state_check();
        resolve_each_type();
        operand_wakeup();
        misaligned_targets();
        stall_and_drain();
        flush_pending();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int HALF_PERIOD = 5;   // 10 ns clock
    localparam int RST_CYCLES  = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Released on a falling edge, clear of the stimulus slot
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/isa_pkg.sv
design/expipe_pkg.sv
design/bu_issue_if.sv
design/modn_counter.sv
design/branch_rs.sv
design/branch_unit.sv
design/branch_exec_top.sv
test/tb_clk_gen.sv
test/tb_branch_exec.sv
